//--- program.hex
// One 32-bit instruction word per line: form/st/deref nibble, Z, X, Y, op, imm[11:0]
// Directed section from word 0, trap handler at 0x11F
01000005
02000FFD
03F00000
00122000
30100040
33000041
4412BFFD
21400000
15000080
35000042
0FF02002
01000FFF
01000FFF
1F0007FE
C0000000
00000000
@11F
0F000120

//--- vlog.f
cpuIsaPkg.sv
cpuBusPkg.sv
regFile.sv
insnDecoder.sv
aluExec.sv
cpuSequencer.sv
cpuTop.sv
cpuTop_assert.sv
cpuTop_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - cpuIsaPkg.sv
  - cpuBusPkg.sv
  - regFile.sv
  - insnDecoder.sv
  - aluExec.sv
  - cpuSequencer.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuTop_assert.sv
      - cpuTop_tb.sv

//--- cpuTop_tb.sv
`timescale 1ns/1ps

module cpuTop_tb;
    import cpuIsaPkg::*;
    import cpuBusPkg::*;

    localparam logic [31:0] ResetVec   = 32'h0000_0000;
    localparam logic [31:0] VecBase    = 32'h0000_0100;
    localparam logic [31:0] Pattern    = 32'h0000_07F0;  // Read data is addr XOR this
    localparam logic [31:0] RandBase   = 32'h0000_0120;  // Reached from the trap handler
    localparam int          NumPairs   = 200;
    localparam logic [31:0] EndAddr    = RandBase + 14 + 2 * NumPairs;
    localparam int          NumInsn    = 16 + 1 + 14 + 2 * NumPairs + 1;
    localparam int          WorstCycles = 20;  // Fetch, exec, wb and two 5-cycle waits
    localparam int          TimeoutNs  = (NumInsn * WorstCycles + 100) * 40;
    localparam logic [2:0]  StateFetch = 3'd1;  // Sequencer state encoding

    logic        clk = 1'b0;
    logic        reset_n;
    logic        i_halt;
    logic [31:0] o_insnAddr;
    insnWord_u   insnWord;
    logic        o_dReqValid;
    dataReq_t    o_dReq;
    logic        i_dAck;
    logic [31:0] i_dRdata;

    logic [31:0] imem [0:1023];
    logic [31:0] mregs [1:14];
    logic [31:0] lcgState = 32'd75019;
    logic [31:0] modelPc;
    dataReq_t    expQ [$];
    dataReq_t    expReq;
    logic        hasReq;
    logic        prevValid = 1'b0;
    logic        done = 1'b0;
    int          fetchCount = 0;
    int          haltCycles = 0;
    int          fetchErrors = 0;
    int          busErrors = 0;
    int          otherErrors = 0;

    cpuTop #(.ResetVector(ResetVec), .VectorBase(VecBase)) dut_i (
        .clk(clk), .reset_n(reset_n), .i_halt(i_halt), .o_insnAddr(o_insnAddr),
        .i_insn(insnWord), .o_dReqValid(o_dReqValid), .o_dReq(o_dReq),
        .i_dAck(i_dAck), .i_dRdata(i_dRdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState ^ (lcgState >> 16);
    endfunction

    function automatic logic [31:0] readReg(input logic [3:0] idx, input logic [31:0] pc);
        if (idx == 4'd0) return 32'd0;
        if (idx == 4'd15) return pc + 32'd1;
        return mregs[idx];
    endfunction

    // One instruction on the model state, returns the next PC
    function automatic logic [31:0] refStep(input logic [31:0] pc, input logic [31:0] w,
                                            output logic hasAcc, output dataReq_t acc);
        logic [31:0] x, y, zv, imm, o, a, res, val;
        logic [3:0]  op;
        hasAcc = 1'b0;
        acc = '0;
        if (w[31:30] == 2'b11) return VecBase | {27'd0, ~w[4:0]};
        x   = readReg(w[23:20], pc);
        y   = readReg(w[19:16], pc);
        zv  = readReg(w[27:24], pc);
        imm = {{20{w[11]}}, w[11:0]};
        o   = w[30] ? imm : y;
        a   = w[30] ? y : imm;
        op  = w[15:12];
        case (op)
            4'd0:  res = x | o;
            4'd1:  res = x & o;
            4'd2:  res = x + o;
            4'd3:  res = x * o;
            4'd5:  res = (o >= 32) ? 32'd0 : x << o;
            4'd6:  res = ($signed(x) < $signed(o)) ? 32'hFFFF_FFFF : 32'd0;
            4'd7:  res = (x == o) ? 32'hFFFF_FFFF : 32'd0;
            4'd8:  res = ($signed(x) > $signed(o)) ? 32'hFFFF_FFFF : 32'd0;
            4'd9:  res = x & ~o;
            4'd10: res = x ^ o;
            4'd11: res = x - o;
            4'd12: res = ~(x ^ o);
            4'd13: res = (o >= 32) ? 32'd0 : x >> o;
            4'd14: res = (x != o) ? 32'hFFFF_FFFF : 32'd0;
            default: res = 32'd0;
        endcase
        val = (op == 4'd4 || op == 4'd15) ? 32'd0 : res + a;
        if (w[29]) begin
            hasAcc = 1'b1;
            acc.write = 1'b1;
            acc.addr  = w[28] ? val : zv;
            acc.wdata = w[28] ? zv : val;
            return pc + 32'd1;
        end
        if (w[28]) begin
            hasAcc = 1'b1;
            acc.addr = val;
            acc.wdata = zv;
            val = val ^ Pattern;  // Load data from the memory model
        end
        if (w[27:24] == 4'd15) return val;
        if (w[27:24] != 4'd0) mregs[w[27:24]] = val;
        return pc + 32'd1;
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // Instruction port lookup
    always @(posedge clk) begin
        #5;
        insnWord <= imem[o_insnAddr];
    end

    // Data memory with random four-phase delays
    always @(posedge clk) begin
        #5;
        if (o_dReqValid && !i_dAck) begin
            idleCycles(nextRand() % 6);
            i_dAck   = 1'b1;
            i_dRdata = o_dReq.addr ^ Pattern;
            do begin
                @(posedge clk);
                #5;
            end while (o_dReqValid);
            idleCycles(nextRand() % 6);
            i_dAck = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (reset_n && !done) begin
            if (dut_i.sequencer_i.state == StateFetch) begin
                assert (o_insnAddr == modelPc) else begin
                    $display("FAILED o_insnAddr: got %h expected %h", o_insnAddr, modelPc);
                    fetchErrors++;
                end
                if (modelPc == EndAddr) begin
                    done = 1'b1;
                end else begin
                    modelPc = refStep(modelPc, imem[modelPc], hasReq, expReq);
                    if (hasReq) expQ.push_back(expReq);
                    fetchCount++;
                end
            end
            if (o_dReqValid && !prevValid) begin
                assert (expQ.size() != 0) else begin
                    $display("Data request issued where no access was predicted");
                    busErrors++;
                end
                if (expQ.size() != 0) begin
                    expReq = expQ.pop_front();
                    assert (o_dReq.addr == expReq.addr && o_dReq.write == expReq.write) else begin
                        $display("FAILED o_dReq.addr/write: got %h/%h expected %h/%h",
                                 o_dReq.addr, o_dReq.write, expReq.addr, expReq.write);
                        busErrors++;
                    end
                    assert (!expReq.write || o_dReq.wdata == expReq.wdata) else begin
                        $display("FAILED o_dReq.wdata: got %h expected %h",
                                 o_dReq.wdata, expReq.wdata);
                        busErrors++;
                    end
                end
            end
            prevValid = o_dReqValid;
            haltCycles = i_halt ? haltCycles + 1 : 0;
            assert (!(haltCycles > 25 && dut_i.sequencer_i.state == StateFetch)) else begin
                $display("Fetch happened while halt was held");
                otherErrors++;
            end
            assert (!(haltCycles > 25 && o_dReqValid)) else begin
                $display("Data request raised while halt was held");
                otherErrors++;
            end
        end
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog timeout, program did not reach its end address");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        reset_n  = 1'b0;
        i_halt   = 1'b0;
        i_dAck   = 1'b0;
        i_dRdata = 32'd0;
        insnWord = '0;
        modelPc  = ResetVec;
        $readmemh("program.hex", imem);
        for (int i = 1; i <= 14; i++) begin
            imem[RandBase + i - 1] = {8'h00, i[3:0], 20'h0} | (nextRand() & 32'h7FF);
        end
        for (int i = 0; i < NumPairs; i++) begin
            w = nextRand();
            w[27:24] = nextRand() % 15;           // Never a branch, r0 allowed
            w[29] = 1'b0;
            w[28] = (nextRand() % 4 == 0);        // Some become loads
            w[31] = 1'b0;
            imem[RandBase + 14 + 2 * i] = w;
            r = nextRand();
            // Indirect store of Z to the immediate address
            imem[RandBase + 15 + 2 * i] = {4'h3, w[27:24], 12'h000, r[11:0]};
        end
        imem[EndAddr] = 32'h0FF0_2FFF;            // Branch to self
        repeat (10) @(posedge clk);
        #5;
        reset_n = 1'b1;
        assert (!o_dReqValid && o_insnAddr == ResetVec) else begin
            $display("FAILED reset state: o_dReqValid %h o_insnAddr %h", o_dReqValid, o_insnAddr);
            otherErrors++;
        end
        wait (fetchCount == 60);
        @(posedge clk);
        #5;
        i_halt = 1'b1;
        idleCycles(40);
        i_halt = 1'b0;
        wait (done);
        assert (expQ.size() == 0) else begin
            $display("Predicted data request was never issued");
            busErrors++;
        end
        $display("Errors: fetch %0d, bus %0d, other %0d", fetchErrors, busErrors, otherErrors);
        if (fetchErrors + busErrors + otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- cpuTop_assert.sv
`timescale 1ns/1ps

module cpuSeqAssert (
    input logic                clk,
    input logic                reset_n,
    input logic                o_dReqValid,
    input cpuBusPkg::dataReq_t o_dReq,
    input logic                i_dAck
);
    import cpuBusPkg::*;

    // Request held until acknowledged
    property reqHeldUntilAck;
        @(posedge clk) disable iff (!reset_n)
            o_dReqValid && !i_dAck |=> o_dReqValid;
    endproperty

    // Payload frozen while the request is up
    property reqStable;
        @(posedge clk) disable iff (!reset_n)
            o_dReqValid && $past(o_dReqValid) |-> $stable(o_dReq);
    endproperty

    // Previous cycle fully closed before a new one
    property noStartDuringAck;
        @(posedge clk) disable iff (!reset_n)
            !o_dReqValid && i_dAck |=> !o_dReqValid;
    endproperty

    assert property (reqHeldUntilAck) else $error("Request dropped before acknowledge");
    assert property (reqStable) else $error("Request payload changed while valid");
    assert property (noStartDuringAck) else $error("Request started while ack still high");

endmodule

bind cpuSequencer cpuSeqAssert seqAssert_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .o_dReqValid(o_dReqValid),
    .o_dReq     (o_dReq),
    .i_dAck     (i_dAck)
);

//--- cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter logic [31:0] ResetVector = cpuBusPkg::ResetVectorDefault,
    parameter logic [31:0] VectorBase  = cpuBusPkg::VectorBaseDefault
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 i_halt,
    output logic [31:0]          o_insnAddr,
    input  cpuIsaPkg::insnWord_u i_insn,
    output logic                 o_dReqValid,
    output cpuBusPkg::dataReq_t  o_dReq,
    input  logic                 i_dAck,
    input  logic [31:0]          i_dRdata
);
    import cpuIsaPkg::*;

    decoded_t    dec;
    logic [31:0] xVal;
    logic [31:0] yVal;
    logic [31:0] zVal;
    logic [31:0] rhs;
    logic [31:0] nextPc;
    logic [31:0] regWdata;
    logic        aluEn;
    logic        regWe;

    cpuSequencer #(
        .ResetVector(ResetVector),
        .VectorBase (VectorBase)
    ) sequencer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_halt     (i_halt),
        .i_insn     (i_insn),
        .i_dec      (dec),
        .i_rhs      (rhs),
        .i_zVal     (zVal),
        .i_dAck     (i_dAck),
        .i_dRdata   (i_dRdata),
        .o_insnAddr (o_insnAddr),
        .o_nextPc   (nextPc),
        .o_aluEn    (aluEn),
        .o_regWe    (regWe),
        .o_regWdata (regWdata),
        .o_dReqValid(o_dReqValid),
        .o_dReq     (o_dReq)
    );

    insnDecoder decoder_i (
        .i_insn(i_insn),
        .o_dec (dec)
    );

    regFile regFile_i (
        .clk     (clk),
        .i_we    (regWe),
        .i_zIdx  (dec.zIdx),
        .i_xIdx  (dec.xIdx),
        .i_yIdx  (dec.yIdx),
        .i_wdata (regWdata),
        .i_nextPc(nextPc),
        .o_xVal  (xVal),
        .o_yVal  (yVal),
        .o_zVal  (zVal)
    );

    aluExec alu_i (
        .clk   (clk),
        .i_en  (aluEn),
        .i_op  (dec.op),
        .i_swap(dec.swap),
        .i_x   (xVal),
        .i_y   (yVal),
        .i_imm (dec.immExt),
        .o_rhs (rhs)
    );

endmodule

//--- cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer #(
    parameter logic [31:0] ResetVector = cpuBusPkg::ResetVectorDefault,
    parameter logic [31:0] VectorBase  = cpuBusPkg::VectorBaseDefault
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 i_halt,
    input  cpuIsaPkg::insnWord_u i_insn,
    input  cpuIsaPkg::decoded_t  i_dec,
    input  logic [31:0]          i_rhs,
    input  logic [31:0]          i_zVal,
    input  logic                 i_dAck,
    input  logic [31:0]          i_dRdata,
    output logic [31:0]          o_insnAddr,
    output logic [31:0]          o_nextPc,
    output logic                 o_aluEn,
    output logic                 o_regWe,
    output logic [31:0]          o_regWdata,
    output logic                 o_dReqValid,
    output cpuBusPkg::dataReq_t  o_dReq
);
    import cpuIsaPkg::*;
    import cpuBusPkg::*;

    typedef enum logic [2:0] {
        StIdle,   // Reset and halt wait
        StFetch,
        StExec,
        StMem,
        StWb
    } seqState_e;

    seqState_e   state;
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] loadData;
    logic [31:0] wbValue;
    logic [31:0] trapTarget;
    logic        reqValid;
    logic        acked;       // Waiting for ack to fall
    logic        isTrapWord;
    logic        memAccess;
    logic        isLoad;
    logic        reqStart;
    logic        reqDone;
    dataReq_t    reqNext;
    dataReq_t    reqHeld;

    // Trap form is recognised straight from the fetched word
    assign isTrapWord = (i_insn.trap.form == TrapForm);
    assign memAccess  = i_dec.storing || i_dec.derefRhs;
    assign isLoad     = i_dec.derefRhs && !i_dec.storing;
    assign trapTarget = VectorBase | {27'd0, ~i_dec.vector};
    assign wbValue    = isLoad ? loadData : i_rhs;

    assign reqStart = (state == StMem) && !reqValid && !acked;
    assign reqDone  = (state == StMem) && reqValid && i_dAck;

    // Plain store writes rhs to [Z], indirect store writes Z to [rhs]
    always_comb begin
        reqNext.write = i_dec.storing;
        reqNext.addr  = i_dec.derefRhs ? i_rhs : i_zVal;
        reqNext.wdata = i_dec.derefRhs ? i_zVal : i_rhs;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= StIdle;
            pc       <= ResetVector;
            reqValid <= 1'b0;
            acked    <= 1'b0;
        end else begin
            case (state)
                StIdle: begin
                    if (!i_halt) state <= StFetch;
                end
                StFetch: begin
                    if (isTrapWord) begin
                        pc    <= trapTarget;  // Straight to the vector fetch
                        state <= i_halt ? StIdle : StFetch;
                    end else begin
                        state <= StExec;
                    end
                end
                StExec: state <= memAccess ? StMem : StWb;
                StMem: begin
                    if (reqStart) begin
                        reqValid <= 1'b1;
                    end else if (reqDone) begin
                        reqValid <= 1'b0;
                        acked    <= 1'b1;
                    end else if (acked && !i_dAck) begin
                        acked <= 1'b0;  // Four-phase cycle closed
                        state <= StWb;
                    end
                end
                StWb: begin
                    pc    <= i_dec.isBranch ? wbValue : nextPc;
                    state <= i_halt ? StIdle : StFetch;
                end
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StFetch) nextPc <= pc + 32'd1;
        if (reqStart) reqHeld <= reqNext;
        if (reqDone) loadData <= i_dRdata;  // Valid while ack is high
    end

    assign o_insnAddr  = pc;
    assign o_nextPc    = nextPc;
    assign o_aluEn     = (state == StExec);
    assign o_regWe     = (state == StWb) && !i_dec.storing && !i_dec.isBranch;
    assign o_regWdata  = wbValue;
    assign o_dReqValid = reqValid;
    assign o_dReq      = reqHeld;

endmodule

//--- aluExec.sv
`timescale 1ns/1ps

module aluExec (
    input  logic              clk,
    input  logic              i_en,
    input  cpuIsaPkg::aluOp_e i_op,
    input  logic              i_swap,
    input  logic [31:0]       i_x,
    input  logic [31:0]       i_y,
    input  logic [31:0]       i_imm,
    output logic [31:0]       o_rhs
);
    import cpuIsaPkg::*;

    logic [31:0] opnd;      // Right operand of op
    logic [31:0] addend;    // Term added afterwards
    logic [31:0] opResult;
    logic        bigShift;
    logic        reserved;

    assign opnd     = i_swap ? i_imm : i_y;
    assign addend   = i_swap ? i_y : i_imm;
    assign bigShift = |opnd[31:5];  // Shift of 32 or more
    assign reserved = (i_op == OpRsvd4) || (i_op == OpRsvd15);

    always_comb begin
        case (i_op)
            OpOr:     opResult = i_x | opnd;
            OpAnd:    opResult = i_x & opnd;
            OpAdd:    opResult = i_x + opnd;
            OpMul:    opResult = i_x * opnd;  // Low 32 bits
            OpShl:    opResult = bigShift ? '0 : i_x << opnd[4:0];
            OpLt:     opResult = {32{$signed(i_x) < $signed(opnd)}};
            OpEq:     opResult = {32{i_x == opnd}};
            OpGt:     opResult = {32{$signed(i_x) > $signed(opnd)}};
            OpAndNot: opResult = i_x & ~opnd;
            OpXor:    opResult = i_x ^ opnd;
            OpSub:    opResult = i_x - opnd;
            OpXnor:   opResult = i_x ^ ~opnd;
            OpShr:    opResult = bigShift ? '0 : i_x >> opnd[4:0];  // Logical
            OpNe:     opResult = {32{i_x != opnd}};
            default:  opResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rhs <= reserved ? '0 : opResult + addend;
        end
    end

endmodule

//--- insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  cpuIsaPkg::insnWord_u i_insn,
    output cpuIsaPkg::decoded_t  o_dec
);
    import cpuIsaPkg::*;

    insnFields_t f;
    trapFields_t t;

    // Same word, two views
    assign f = i_insn.fields;
    assign t = i_insn.trap;

    always_comb begin
        o_dec.zIdx     = f.z;
        o_dec.xIdx     = f.x;
        o_dec.yIdx     = f.y;
        o_dec.op       = f.op;
        o_dec.immExt   = {{20{f.imm[11]}}, f.imm};  // Sign extend
        o_dec.swap     = f.form[0];                  // Bit 30
        o_dec.storing  = f.storing;
        o_dec.derefRhs = f.derefRhs;
        o_dec.isBranch = (f.z == RegPc) && !f.storing;
        o_dec.isTrap   = (t.form == TrapForm);
        o_dec.vector   = t.vector;
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        i_we,
    input  logic [3:0]  i_zIdx,
    input  logic [3:0]  i_xIdx,
    input  logic [3:0]  i_yIdx,
    input  logic [31:0] i_wdata,
    input  logic [31:0] i_nextPc,
    output logic [31:0] o_xVal,
    output logic [31:0] o_yVal,
    output logic [31:0] o_zVal
);
    import cpuIsaPkg::*;

    logic [31:0] regs [1:14];  // General registers only

    function automatic logic [31:0] readPort(input logic [3:0] idx);
        logic [31:0] val;
        if (idx == RegZero) begin
            val = '0;
        end else if (idx == RegPc) begin
            val = i_nextPc;  // PC reads as the following address
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        o_xVal = readPort(i_xIdx);
        o_yVal = readPort(i_yIdx);
        o_zVal = readPort(i_zIdx);
    end

    // Index 15 writes come through the sequencer as branches
    always_ff @(posedge clk) begin
        if (i_we && i_zIdx != RegZero && i_zIdx != RegPc) begin
            regs[i_zIdx] <= i_wdata;
        end
    end

endmodule

//--- cpuBusPkg.sv
package cpuBusPkg;

    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // Word address of the first fetch after reset
    localparam logic [AddrWidth-1:0] ResetVectorDefault = 32'h0000_0000;

    // Trap targets are VectorBase OR the complemented 5-bit vector,
    // so the low five bits of the base must stay clear
    localparam logic [AddrWidth-1:0] VectorBaseDefault = 32'h0000_0100;

    // One data-bus transfer, held stable while the request is raised
    typedef struct packed {
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;  // Ignored on reads
        logic                 write;
    } dataReq_t;

endpackage

//--- cpuIsaPkg.sv
package cpuIsaPkg;

    // Special register indices
    localparam logic [3:0] RegZero = 4'd0;   // Always reads zero
    localparam logic [3:0] RegPc   = 4'd15;  // Reads next PC, write is a branch

    localparam logic [1:0] TrapForm = 2'b11;  // Form value of the trap layout

    // ALU operation codes, Z = (X op O) + A
    typedef enum logic [3:0] {
        OpOr,
        OpAnd,
        OpAdd,
        OpMul,
        OpRsvd4,
        OpShl,
        OpLt,
        OpEq,
        OpGt,
        OpAndNot,
        OpXor,
        OpSub,
        OpXnor,
        OpShr,
        OpNe,
        OpRsvd15
    } aluOp_e;

    // Normal three-operand layout
    typedef struct packed {
        logic [1:0]  form;      // Bit 30 selects the Y/immediate swap
        logic        storing;
        logic        derefRhs;  // Right-hand side is a memory address
        logic [3:0]  z;
        logic [3:0]  x;
        logic [3:0]  y;
        aluOp_e      op;
        logic [11:0] imm;       // Signed
    } insnFields_t;

    // Trap layout of the same word
    typedef struct packed {
        logic [1:0]  form;
        logic [24:0] unused;
        logic [4:0]  vector;
    } trapFields_t;

    typedef union packed {
        insnFields_t fields;
        trapFields_t trap;
    } insnWord_u;

    // Decoder output
    typedef struct packed {
        logic [3:0]  zIdx;
        logic [3:0]  xIdx;
        logic [3:0]  yIdx;
        aluOp_e      op;
        logic [31:0] immExt;
        logic        swap;
        logic        storing;
        logic        derefRhs;
        logic        isBranch;
        logic        isTrap;
        logic [4:0]  vector;
    } decoded_t;

endpackage
